// File: Makefile
VERILATOR  ?= verilator
FILELIST   := project.f
TOP        := tb_operand_fetch
RTL_TOP    := operand_fetch_top
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --timescale 1ns/1ps
PASS_MSG   := Regression passed

SOURCES    := $(shell cat $(FILELIST))
SIM_BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/gpr_file.sv
// General purpose register file
// Three combinational read ports, one single or pair write port
// x0 reads as zero and is never stored
`default_nettype none

module gpr_file #(
    parameter bit CLEAR_ON_RESET = 1'b1           // Zero all registers on rst
) (
    input  logic                    g_clk,
    input  logic                    rst,
    input  pipe_cfg_pkg::reg_addr_t rs1_addr,     // Source 1 address
    input  pipe_cfg_pkg::reg_addr_t rs2_addr,     // Source 2 address
    input  pipe_cfg_pkg::reg_addr_t rs3_addr,     // Source 3 address
    input  logic                    rd_wen,       // Write enable
    input  logic                    rd_wide,      // Register pair write
    input  pipe_cfg_pkg::reg_addr_t rd_addr,      // Destination address
    input  pipe_cfg_pkg::word_t     rd_wdata,     // Low word, goes to rd
    input  pipe_cfg_pkg::word_t     rd_wdata_hi,  // High word, goes to rd+1
    output pipe_cfg_pkg::word_t     rs1_rdata,
    output pipe_cfg_pkg::word_t     rs2_rdata,
    output pipe_cfg_pkg::word_t     rs3_rdata
);
    import pipe_cfg_pkg::*;

    localparam int NUM_REGS = 2 ** REG_AW;

    word_t     regs [1:NUM_REGS-1];               // No storage for x0
    logic      wr_lo;                             // Write rd itself
    logic      wr_hi;                             // Write odd partner of even rd
    reg_addr_t hi_addr;                           // rd with bit 0 forced high

    // --------------------------------------
    // Write side with the pair rule
    // --------------------------------------
    assign wr_lo   = rd_wen && (rd_addr != '0);             // x0 silently dropped
    assign wr_hi   = rd_wen && rd_wide && !rd_addr[0];      // Odd rd writes one reg
    assign hi_addr = {rd_addr[REG_AW-1:1], 1'b1};

    always_ff @(posedge g_clk) begin
        if (rst && CLEAR_ON_RESET) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_lo) begin
                regs[rd_addr] <= rd_wdata;
            end
            if (wr_hi) begin
                regs[hi_addr] <= rd_wdata_hi;                // rd = x0 lands here only
            end
        end
    end

    // --------------------------------------
    // Read side
    // --------------------------------------
    function automatic word_t read_port(input reg_addr_t addr);
        return (addr == '0) ? '0 : regs[addr];              // Hard zero for x0
    endfunction

    // Re-evaluates on a register write as well as on an address change
    always_comb begin
        rs1_rdata = read_port(rs1_addr);
        rs2_rdata = read_port(rs2_addr);
        rs3_rdata = read_port(rs3_addr);
    end

endmodule

`default_nettype wire

// File: hdl/hazard_detect.sv
// Hazard detection for the decode stage sources
// Source versus s2/s3/s4 destination matching with pair writes
// High half selection and load/CSR bubble decision
`default_nettype none

module hazard_detect (
    input  pipe_cfg_pkg::reg_addr_t            s1_rs1_addr,
    input  pipe_cfg_pkg::reg_addr_t            s1_rs2_addr,
    input  pipe_cfg_pkg::reg_addr_t            s1_rs3_addr,
    input  pipe_ctrl_pkg::fwd_kind_t           fwd_s2_kind,  // Execute stage content
    input  pipe_ctrl_pkg::fwd_kind_t           fwd_s3_kind,  // Memory stage content
    input  pipe_ctrl_pkg::fwd_kind_t           fwd_s4_kind,  // Writeback stage content
    input  pipe_cfg_pkg::reg_addr_t            fwd_s2_rd,
    input  pipe_cfg_pkg::reg_addr_t            fwd_s3_rd,
    input  pipe_cfg_pkg::reg_addr_t            gpr_rd,
    input  logic                               fwd_s2_wide,
    input  logic                               fwd_s3_wide,
    input  logic                               gpr_wide,
    input  logic                               gpr_wen,
    output logic [pipe_ctrl_pkg::NUM_SRC-1:0]  hit_s2,       // One bit per source
    output logic [pipe_ctrl_pkg::NUM_SRC-1:0]  hit_s3,
    output logic [pipe_ctrl_pkg::NUM_SRC-1:0]  hit_s4,
    output logic [pipe_ctrl_pkg::NUM_SRC-1:0]  hi_s2,        // Take the high word
    output logic [pipe_ctrl_pkg::NUM_SRC-1:0]  hi_s3,
    output logic [pipe_ctrl_pkg::NUM_SRC-1:0]  hi_s4,
    output logic                               bubble        // Hold decode this cycle
);
    import pipe_cfg_pkg::*;
    import pipe_ctrl_pkg::*;

    reg_addr_t src [NUM_SRC];                     // Sources in port order
    logic      s2_act;                            // Stage carries a GPR write
    logic      s3_act;
    logic      s4_act;
    logic      csr_any;                           // Some stage holds a CSR op
    logic      load_hit;                          // Outstanding load feeds a source

    assign src[0] = s1_rs1_addr;
    assign src[1] = s1_rs2_addr;
    assign src[2] = s1_rs3_addr;

    assign s2_act = (fwd_s2_kind != FWD_NONE);
    assign s3_act = (fwd_s3_kind != FWD_NONE);
    assign s4_act = (fwd_s4_kind != FWD_NONE) && gpr_wen;   // Only a live write

    // --------------------------------------
    // Match rule
    // --------------------------------------
    // Same register pair, then either an exact nonzero hit or
    // the odd half of a wide write to the even register
    function automatic logic src_match(input reg_addr_t s, input reg_addr_t rd,
                                       input logic wide);
        logic upper_eq;
        logic exact;
        logic pair_hi;
        upper_eq = (s[REG_AW-1:1] == rd[REG_AW-1:1]);
        exact    = (s == rd) && (s != '0);
        pair_hi  = s[0] && !rd[0] && wide;
        return upper_eq && (exact || pair_hi);
    endfunction

    for (genvar i = 0; i < NUM_SRC; i++) begin : g_src
        assign hit_s2[i] = s2_act && src_match(src[i], fwd_s2_rd, fwd_s2_wide);
        assign hit_s3[i] = s3_act && src_match(src[i], fwd_s3_rd, fwd_s3_wide);
        assign hit_s4[i] = s4_act && src_match(src[i], gpr_rd, gpr_wide);
        assign hi_s2[i]  = src[i][0] && fwd_s2_wide;         // Odd source, wide stage
        assign hi_s3[i]  = src[i][0] && fwd_s3_wide;
        assign hi_s4[i]  = src[i][0] && gpr_wide;
    end

    // --------------------------------------
    // Bubble
    // --------------------------------------
    assign csr_any  = (fwd_s2_kind == FWD_CSR) ||
                      (fwd_s3_kind == FWD_CSR) ||
                      (fwd_s4_kind == FWD_CSR);              // CSR result unknown yet

    assign load_hit = ((fwd_s2_kind == FWD_LOAD) && |hit_s2) ||
                      ((fwd_s3_kind == FWD_LOAD) && |hit_s3) ||
                      ((fwd_s4_kind == FWD_LOAD) && |hit_s4);

    assign bubble = csr_any || load_hit;

endmodule

`default_nettype wire

// File: hdl/operand_fetch_top.sv
// Operand fetch top level
// Register file, hazard detection and operand selection
// Later stages appear only as their forwarding buses
`default_nettype none

module operand_fetch_top #(
    parameter bit CLEAR_ON_RESET = 1'b1                       // Passed to gpr_file
) (
    input  logic                     g_clk,
    input  logic                     rst,
    input  logic                     s1_valid,                 // Decode item
    input  pipe_cfg_pkg::reg_addr_t  s1_rs1_addr,
    input  pipe_cfg_pkg::reg_addr_t  s1_rs2_addr,
    input  pipe_cfg_pkg::reg_addr_t  s1_rs3_addr,
    input  pipe_ctrl_pkg::fwd_kind_t fwd_s2_kind,              // Execute stage bus
    input  pipe_cfg_pkg::reg_addr_t  fwd_s2_rd,
    input  logic                     fwd_s2_wide,
    input  pipe_cfg_pkg::word_t      fwd_s2_wdata,
    input  pipe_cfg_pkg::word_t      fwd_s2_wdata_hi,
    input  pipe_ctrl_pkg::fwd_kind_t fwd_s3_kind,              // Memory stage bus
    input  pipe_cfg_pkg::reg_addr_t  fwd_s3_rd,
    input  logic                     fwd_s3_wide,
    input  pipe_cfg_pkg::word_t      fwd_s3_wdata,
    input  pipe_cfg_pkg::word_t      fwd_s3_wdata_hi,
    input  logic                     gpr_wen,                  // Writeback bus
    input  logic                     gpr_wide,
    input  pipe_cfg_pkg::reg_addr_t  gpr_rd,
    input  pipe_cfg_pkg::word_t      gpr_wdata,
    input  pipe_cfg_pkg::word_t      gpr_wdata_hi,
    input  pipe_ctrl_pkg::fwd_kind_t fwd_s4_kind,
    input  logic                     s2_busy,
    input  logic                     flush,
    output logic                     s1_busy,
    output logic                     s2_valid,
    output pipe_cfg_pkg::word_t      s2_rs1_rdata,
    output pipe_cfg_pkg::word_t      s2_rs2_rdata,
    output pipe_cfg_pkg::word_t      s2_rs3_rdata
);
    import pipe_cfg_pkg::*;
    import pipe_ctrl_pkg::*;

    word_t              rs1_rdata;                // Register file to forwarding
    word_t              rs2_rdata;
    word_t              rs3_rdata;
    logic [NUM_SRC-1:0] hit_s2;                   // Hazard results per source
    logic [NUM_SRC-1:0] hit_s3;
    logic [NUM_SRC-1:0] hit_s4;
    logic [NUM_SRC-1:0] hi_s2;
    logic [NUM_SRC-1:0] hi_s3;
    logic [NUM_SRC-1:0] hi_s4;
    logic               bubble;

    // --------------------------------------
    // Register file
    // --------------------------------------
    gpr_file #(
        .CLEAR_ON_RESET (CLEAR_ON_RESET)
    ) u_gpr_file (
        .g_clk          (g_clk),
        .rst            (rst),
        .rs1_addr       (s1_rs1_addr),
        .rs2_addr       (s1_rs2_addr),
        .rs3_addr       (s1_rs3_addr),
        .rd_wen         (gpr_wen),
        .rd_wide        (gpr_wide),
        .rd_addr        (gpr_rd),
        .rd_wdata       (gpr_wdata),
        .rd_wdata_hi    (gpr_wdata_hi),
        .rs1_rdata      (rs1_rdata),
        .rs2_rdata      (rs2_rdata),
        .rs3_rdata      (rs3_rdata)
    );

    // --------------------------------------
    // Hazards and forwarding
    // --------------------------------------
    hazard_detect u_hazard_detect (.*);           // Port names match top nets

    operand_select u_operand_select (.*);

endmodule

`default_nettype wire

// File: hdl/operand_select.sv
// Operand forwarding and the s2 operand register
// Priority mux s2 > s3 > writeback > register file per source
// Valid/busy hand-off with flush
`default_nettype none

module operand_select (
    input  logic                               g_clk,
    input  logic                               rst,
    input  logic                               s1_valid,      // Decode item present
    input  logic                               s2_busy,       // Downstream stall
    input  logic                               flush,         // Drop the s2 item
    input  logic                               bubble,        // Hazard hold
    input  logic [pipe_ctrl_pkg::NUM_SRC-1:0]  hit_s2,
    input  logic [pipe_ctrl_pkg::NUM_SRC-1:0]  hit_s3,
    input  logic [pipe_ctrl_pkg::NUM_SRC-1:0]  hit_s4,
    input  logic [pipe_ctrl_pkg::NUM_SRC-1:0]  hi_s2,
    input  logic [pipe_ctrl_pkg::NUM_SRC-1:0]  hi_s3,
    input  logic [pipe_ctrl_pkg::NUM_SRC-1:0]  hi_s4,
    input  pipe_cfg_pkg::word_t                rs1_rdata,     // Register file reads
    input  pipe_cfg_pkg::word_t                rs2_rdata,
    input  pipe_cfg_pkg::word_t                rs3_rdata,
    input  pipe_cfg_pkg::word_t                fwd_s2_wdata,
    input  pipe_cfg_pkg::word_t                fwd_s2_wdata_hi,
    input  pipe_cfg_pkg::word_t                fwd_s3_wdata,
    input  pipe_cfg_pkg::word_t                fwd_s3_wdata_hi,
    input  pipe_cfg_pkg::word_t                gpr_wdata,
    input  pipe_cfg_pkg::word_t                gpr_wdata_hi,
    output logic                               s1_busy,
    output logic                               s2_valid,
    output pipe_cfg_pkg::word_t                s2_rs1_rdata,
    output pipe_cfg_pkg::word_t                s2_rs2_rdata,
    output pipe_cfg_pkg::word_t                s2_rs3_rdata
);
    import pipe_cfg_pkg::*;
    import pipe_ctrl_pkg::*;

    word_t rf_rdata  [NUM_SRC];                   // Raw register reads
    word_t fwd_rdata [NUM_SRC];                   // After forwarding
    word_t s2_rdata  [NUM_SRC];                   // Registered operands
    logic  accept;                                // Decode item moves into s2
    logic  consume;                               // s2 item leaves downstream

    assign rf_rdata[0] = rs1_rdata;
    assign rf_rdata[1] = rs2_rdata;
    assign rf_rdata[2] = rs3_rdata;

    // --------------------------------------
    // Forwarding muxes
    // --------------------------------------
    for (genvar i = 0; i < NUM_SRC; i++) begin : g_fwd
        assign fwd_rdata[i] =
            hit_s2[i] ? (hi_s2[i] ? fwd_s2_wdata_hi : fwd_s2_wdata) :   // Youngest wins
            hit_s3[i] ? (hi_s3[i] ? fwd_s3_wdata_hi : fwd_s3_wdata) :
            hit_s4[i] ? (hi_s4[i] ? gpr_wdata_hi    : gpr_wdata   ) :
                        rf_rdata[i];
    end

    // --------------------------------------
    // Handshake
    // --------------------------------------
    assign s1_busy = bubble || (s2_valid && s2_busy);
    assign accept  = s1_valid && !s1_busy && !flush;         // Flush blocks the load
    assign consume = s2_valid && !s2_busy;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else if (flush) begin
            s2_valid <= 1'b0;
        end else if (accept) begin
            s2_valid <= 1'b1;                                // Also covers consume+accept
        end else if (consume) begin
            s2_valid <= 1'b0;
        end
    end

    // Payload only moves on accept, so a stalled s2 holds steady
    always_ff @(posedge g_clk) begin
        if (accept) begin
            for (int i = 0; i < NUM_SRC; i++) begin
                s2_rdata[i] <= fwd_rdata[i];
            end
        end
    end

    assign s2_rs1_rdata = s2_rdata[0];
    assign s2_rs2_rdata = s2_rdata[1];
    assign s2_rs3_rdata = s2_rdata[2];

endmodule

`default_nettype wire

// File: hdl/pipe_cfg_pkg.sv
// Data path sizing for the operand fetch logic
// Word width, register address width and their types
`default_nettype none

package pipe_cfg_pkg;

    // --------------------------------------
    // Widths
    // --------------------------------------
    localparam int XLEN   = 32;                  // Data word width
    localparam int REG_AW = 5;                   // GPR address width, x0..x31

    // --------------------------------------
    // Types
    // --------------------------------------
    typedef logic [XLEN-1:0]   word_t;           // One data word
    typedef logic [REG_AW-1:0] reg_addr_t;       // One GPR address

endpackage

`default_nettype wire

// File: hdl/pipe_ctrl_pkg.sv
// Pipeline control definitions
// Forwarding stage kind and source port count
`default_nettype none

package pipe_ctrl_pkg;

    localparam int NUM_SRC = 3;                  // rs1, rs2, rs3

    // What a later stage holds on its forwarding bus
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,                         // Empty or no GPR write
        FWD_ALU  = 2'd1,                         // Result ready to forward
        FWD_LOAD = 2'd2,                         // Load data still outstanding
        FWD_CSR  = 2'd3                          // CSR access in flight
    } fwd_kind_t;

endpackage

`default_nettype wire

// File: project.f
hdl/pipe_cfg_pkg.sv
hdl/pipe_ctrl_pkg.sv
hdl/gpr_file.sv
hdl/hazard_detect.sv
hdl/operand_select.sv
hdl/operand_fetch_top.sv
tb/tb_operand_fetch.sv

// File: tb/tb_operand_fetch.sv
// Self-checking testbench for the operand fetch top level
// Register preload with a shadow model, stimulus table applied in a loop
// Compare tasks, error count and a cycle limit
`default_nettype none

module tb_operand_fetch;
    timeunit 1ns;
    timeprecision 1ps;

    import pipe_cfg_pkg::*;
    import pipe_ctrl_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int SETUP_CYCLES = 36;                 // 34 writes, release, reset check
    localparam int NUM_ROWS     = 13;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + SETUP_CYCLES + 4 * NUM_ROWS + 16;
    localparam int SEED         = 32'h8b52b28b;

    // One later stage as seen on its forwarding bus
    typedef struct packed {
        fwd_kind_t kind;
        reg_addr_t rd;
        logic      wide;
        word_t     lo;
        word_t     hi;
    } stage_t;

    // Stimulus first, expected values last
    typedef struct packed {
        stage_t    s2;
        stage_t    s3;
        stage_t    s4;                                // Writeback with wen while kind set
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rs3;
        logic      stall;                             // Drives s2_busy
        logic      fl;                                // Drives flush
        logic      exp_busy;                          // s1_busy right after drive
        word_t     exp1;
        word_t     exp2;
        word_t     exp3;
    } row_t;

    logic      g_clk;
    logic      rst;
    logic      s1_valid;
    reg_addr_t s1_rs1_addr;
    reg_addr_t s1_rs2_addr;
    reg_addr_t s1_rs3_addr;
    fwd_kind_t fwd_s2_kind;
    reg_addr_t fwd_s2_rd;
    logic      fwd_s2_wide;
    word_t     fwd_s2_wdata;
    word_t     fwd_s2_wdata_hi;
    fwd_kind_t fwd_s3_kind;
    reg_addr_t fwd_s3_rd;
    logic      fwd_s3_wide;
    word_t     fwd_s3_wdata;
    word_t     fwd_s3_wdata_hi;
    logic      gpr_wen;
    logic      gpr_wide;
    reg_addr_t gpr_rd;
    word_t     gpr_wdata;
    word_t     gpr_wdata_hi;
    fwd_kind_t fwd_s4_kind;
    logic      s2_busy;
    logic      flush;
    logic      s1_busy;
    logic      s2_valid;
    word_t     s2_rs1_rdata;
    word_t     s2_rs2_rdata;
    word_t     s2_rs3_rdata;

    word_t     shadow [0:31];                         // Expected GPR contents
    row_t      rows [$];
    string     names [$];
    word_t     pair_lo;                               // Wide write to x10
    word_t     pair_hi;
    word_t     zero_hi;                               // Wide write to x0 lands in x1
    word_t     odd_lo;                                // Wide write to odd x7
    int        errors = 0;
    int        checks = 0;
    int        cycles = 0;

    operand_fetch_top #(
        .CLEAR_ON_RESET (1'b1)
    ) dut (.*);

    always #4 g_clk = ~g_clk;                         // 8 ns period

    always @(posedge g_clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    // --------------------------------------
    // Compare tasks
    // --------------------------------------
    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Even rd wide also fills rd+1 and x0 is never stored
    function automatic void record_write(input reg_addr_t rd, input logic wide,
                                         input word_t lo, input word_t hi);
        if (rd != 5'd0)
            shadow[rd] = lo;
        if (wide && !rd[0])
            shadow[rd | 5'd1] = hi;
    endfunction

    task automatic write_reg(input reg_addr_t rd, input logic wide,
                             input word_t lo, input word_t hi);
        @(negedge g_clk);
        gpr_wen      = 1'b1;
        gpr_wide     = wide;
        gpr_rd       = rd;
        gpr_wdata    = lo;
        gpr_wdata_hi = hi;
        record_write(rd, wide, lo, hi);
    endtask

    // --------------------------------------
    // Stimulus table
    // --------------------------------------
    function automatic stage_t stg(input fwd_kind_t kind, input reg_addr_t rd,
                                   input logic wide, input word_t lo, input word_t hi);
        return '{kind, rd, wide, lo, hi};
    endfunction

    task automatic add_row(input string name, input stage_t s2, input stage_t s3,
                           input stage_t s4, input reg_addr_t rs1, input reg_addr_t rs2,
                           input reg_addr_t rs3, input logic stall, input logic fl,
                           input logic eb, input word_t e1, input word_t e2, input word_t e3);
        names.push_back(name);
        rows.push_back('{s2, s3, s4, rs1, rs2, rs3, stall, fl, eb, e1, e2, e3});
    endtask

    task automatic build_table();
        stage_t off;
        off = stg(FWD_NONE, 5'd0, 1'b0, '0, '0);
        add_row("rf_read", off, off, off, 5'd3, 5'd0, 5'd31, 1'b0, 1'b0, 1'b0,
                shadow[3], '0, shadow[31]);
        add_row("pair_even", off, off, off, 5'd10, 5'd11, 5'd1, 1'b0, 1'b0, 1'b0,
                pair_lo, pair_hi, zero_hi);
        add_row("pair_odd", off, off, off, 5'd7, 5'd8, 5'd0, 1'b0, 1'b0, 1'b0,
                odd_lo, shadow[8], '0);                             // x8 left alone
        add_row("prio_s2", stg(FWD_ALU, 5'd20, 1'b0, 32'ha200_0014, 32'ha2ff_0014),
                stg(FWD_ALU, 5'd20, 1'b0, 32'ha300_0014, 32'ha3ff_0014),
                stg(FWD_ALU, 5'd20, 1'b0, 32'ha400_0014, 32'ha4ff_0014),
                5'd20, 5'd21, 5'd20, 1'b0, 1'b0, 1'b0,
                32'ha200_0014, shadow[21], 32'ha200_0014);
        add_row("prio_s3", stg(FWD_NONE, 5'd20, 1'b0, 32'ha200_0014, 32'ha2ff_0014),
                stg(FWD_ALU, 5'd20, 1'b0, 32'ha300_0014, 32'ha3ff_0014),
                stg(FWD_ALU, 5'd20, 1'b0, 32'ha400_0014, 32'ha4ff_0014),
                5'd20, 5'd0, 5'd22, 1'b0, 1'b0, 1'b0,
                32'ha300_0014, '0, shadow[22]);                     // Empty s2 skipped
        add_row("prio_s4", off, off,
                stg(FWD_ALU, 5'd22, 1'b1, 32'ha400_0016, 32'ha4ff_0016),
                5'd22, 5'd23, 5'd21, 1'b0, 1'b0, 1'b0,
                32'ha400_0016, 32'ha4ff_0016, shadow[21]);
        add_row("wide_hi", stg(FWD_ALU, 5'd12, 1'b1, 32'ha200_000c, 32'ha2ff_000c),
                stg(FWD_ALU, 5'd0, 1'b1, 32'ha300_0000, 32'ha3ff_0000), off,
                5'd13, 5'd12, 5'd1, 1'b0, 1'b0, 1'b0,
                32'ha2ff_000c, 32'ha200_000c, 32'ha3ff_0000);       // x1 from wide x0
        add_row("load_nomatch", stg(FWD_LOAD, 5'd18, 1'b0, 32'ha200_0012, '0), off, off,
                5'd17, 5'd19, 5'd16, 1'b0, 1'b0, 1'b0,
                shadow[17], shadow[19], shadow[16]);
        add_row("load_pair", stg(FWD_LOAD, 5'd26, 1'b1, 32'ha200_001a, 32'ha2ff_001a),
                off, off, 5'd27, 5'd3, 5'd0, 1'b0, 1'b0, 1'b1,
                32'ha2ff_001a, shadow[3], '0);
        add_row("load_s3", off, stg(FWD_LOAD, 5'd15, 1'b0, 32'ha300_000f, '0), off,
                5'd2, 5'd15, 5'd0, 1'b0, 1'b0, 1'b1,
                shadow[2], 32'ha300_000f, '0);
        add_row("csr_any", stg(FWD_CSR, 5'd30, 1'b0, 32'ha200_001e, '0), off, off,
                5'd4, 5'd9, 5'd14, 1'b0, 1'b0, 1'b1,
                shadow[4], shadow[9], shadow[14]);                  // No source match
        add_row("stall", off, off, off, 5'd24, 5'd25, 5'd5, 1'b1, 1'b0, 1'b1,
                shadow[24], shadow[25], shadow[5]);
        add_row("flush", off, off, off, 5'd6, 5'd28, 5'd29, 1'b1, 1'b1, 1'b1,
                shadow[6], shadow[28], shadow[29]);
    endtask

    // --------------------------------------
    // Row application
    // --------------------------------------
    task automatic drive_row(input row_t r);
        fwd_s2_kind     = r.s2.kind;
        fwd_s2_rd       = r.s2.rd;
        fwd_s2_wide     = r.s2.wide;
        fwd_s2_wdata    = r.s2.lo;
        fwd_s2_wdata_hi = r.s2.hi;
        fwd_s3_kind     = r.s3.kind;
        fwd_s3_rd       = r.s3.rd;
        fwd_s3_wide     = r.s3.wide;
        fwd_s3_wdata    = r.s3.lo;
        fwd_s3_wdata_hi = r.s3.hi;
        fwd_s4_kind     = r.s4.kind;
        gpr_wen         = (r.s4.kind != FWD_NONE);
        gpr_rd          = r.s4.rd;
        gpr_wide        = r.s4.wide;
        gpr_wdata       = r.s4.lo;
        gpr_wdata_hi    = r.s4.hi;
        s1_rs1_addr     = r.rs1;
        s1_rs2_addr     = r.rs2;
        s1_rs3_addr     = r.rs3;
        s2_busy         = r.stall;
        flush           = r.fl;
        s1_valid        = 1'b1;
    endtask

    // Outstanding loads and CSR ops complete
    task automatic promote_stages();
        if (fwd_s2_kind != FWD_NONE)
            fwd_s2_kind = FWD_ALU;
        if (fwd_s3_kind != FWD_NONE)
            fwd_s3_kind = FWD_ALU;
        if (fwd_s4_kind != FWD_NONE)
            fwd_s4_kind = FWD_ALU;
    endtask

    task automatic apply_row(input int idx);
        row_t  r;
        string n;
        word_t held1;
        word_t held2;
        word_t held3;
        r = rows[idx];
        n = names[idx];
        drive_row(r);                                 // Called on a falling edge
        #1;
        check_flag({n, " s1_busy"}, r.exp_busy, s1_busy);
        if (r.fl) begin
            @(negedge g_clk);
            check_flag({n, " s2_valid after flush"}, 1'b0, s2_valid);
            flush   = 1'b0;
            s2_busy = 1'b0;
        end else if (r.stall) begin
            held1 = s2_rs1_rdata;
            held2 = s2_rs2_rdata;
            held3 = s2_rs3_rdata;
            repeat (2) begin
                @(negedge g_clk);
                check_flag({n, " s2_valid held"}, 1'b1, s2_valid);
                check_flag({n, " s1_busy held"}, 1'b1, s1_busy);
                check_word({n, " rs1 held"}, held1, s2_rs1_rdata);
                check_word({n, " rs2 held"}, held2, s2_rs2_rdata);
                check_word({n, " rs3 held"}, held3, s2_rs3_rdata);
            end
            s2_busy = 1'b0;
        end else if (r.exp_busy) begin
            repeat (2) begin
                @(negedge g_clk);
                check_flag({n, " s2_valid in bubble"}, 1'b0, s2_valid);
                check_flag({n, " s1_busy in bubble"}, 1'b1, s1_busy);
            end
            promote_stages();
        end
        #1;
        while (s1_busy) begin                         // Wait out hazard or stall
            @(negedge g_clk);
            #1;
        end
        @(negedge g_clk);                             // Accepted at the edge before
        s1_valid = 1'b0;
        check_flag({n, " s2_valid"}, 1'b1, s2_valid);
        check_word({n, " rs1"}, r.exp1, s2_rs1_rdata);
        check_word({n, " rs2"}, r.exp2, s2_rs2_rdata);
        check_word({n, " rs3"}, r.exp3, s2_rs3_rdata);
        if (r.s4.kind != FWD_NONE)
            record_write(r.s4.rd, r.s4.wide, r.s4.lo, r.s4.hi);
    endtask

    // --------------------------------------
    // Main sequence
    // --------------------------------------
    initial begin
        g_clk = 1'b0;
        rst   = 1'b1;
        drive_row('0);                                // All kinds FWD_NONE
        s1_valid = 1'b0;
        for (int i = 0; i < 32; i++)
            shadow[i] = '0;                           // Cleared on reset
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge g_clk);
        @(negedge g_clk);
        rst = 1'b0;
        @(negedge g_clk);
        check_flag("reset s2_valid", 1'b0, s2_valid);
        check_flag("reset s1_busy", 1'b0, s1_busy);

        for (int i = 1; i < 32; i++)
            write_reg(reg_addr_t'(i), 1'b0, $urandom(), '0);
        pair_lo = $urandom();
        pair_hi = $urandom();
        zero_hi = $urandom();
        odd_lo  = $urandom();
        write_reg(5'd10, 1'b1, pair_lo, pair_hi);
        write_reg(5'd0, 1'b1, $urandom(), zero_hi);
        write_reg(5'd7, 1'b1, odd_lo, $urandom());    // High word dropped
        @(negedge g_clk);
        gpr_wen = 1'b0;

        build_table();
        for (int i = 0; i < rows.size(); i++)
            apply_row(i);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
